/* tb.f */
logic/rf_ctrl_pkg.sv
logic/agc_dsa_ctrl.sv
logic/pa_overdrive_guard.sv
logic/srx_ant_select.sv
logic/spi_bank_mux.sv
logic/rf_control.sv
sim/rf_control_tb.sv

/* sim/rf_control_tb.sv */
`timescale 1ns/100ps

module rf_control_tb import rf_ctrl_pkg::*;;

    localparam int N           = 4;     // DUT defaults
    localparam int ODP_PERSIST = 4;
    localparam int SRX_DWELL   = 16;
    localparam int MAX_ROWS    = 20;
    localparam logic [27:0] PS_A = {7'd40, 7'd30, 7'd20, 7'd10};   // ch3 .. ch0
    localparam logic [27:0] PS_B = {7'd120, 7'd30, 7'd20, 7'd10};  // ch3 near the ceiling

    logic clk_3x = 1'b0;
    logic rst = 1'b1;
    logic [N-1:0] adc_over_range, adcp_disable, rx_dsa_le, host_sleep;
    dsa_atten_t ps_rxdsa [N];
    dsa_atten_t pl_rxdsa [N];
    dsa_atten_t rx_dsa_d;
    tssi_t tssi [N];
    tssi_t rf_overdrive_tssi [N];
    tssi_t tssi_limit;
    logic odp_clear, pa_irq, srx_auto, spi_bank_sel, spi_sclk, spi_mosi, pa_spi1_miso;
    logic [N-1:0] odp_flag, pa_ctrl_sleep, rf_switch_n, rf_switch_en_n;
    ant_idx_t srx_ant_req, srx_wrssi_ant;
    logic [6:0] spi_ss_n;
    logic spi_miso, spi_tx_clk, spi_tx_d, spi_orx_clk, spi_orx_d;
    logic pa_spi1_sclk, pa_spi1_mosi, pa_spi2_sclk, pa_spi2_mosi, pa_spi3_sclk, pa_spi3_mosi;
    logic [3:0] spi_tx_le;
    logic [2:0] pa_spi1_cs;
    logic [1:0] spi_orx_le, pa_spi2_le, pa_spi3_le;

    // stimulus table with one entry per row
    logic [N-1:0] t_or [MAX_ROWS], t_dis [MAX_ROWS], t_hot [MAX_ROWS];
    logic [27:0]  t_ps [MAX_ROWS];
    tssi_t        t_tval [MAX_ROWS], t_lim [MAX_ROWS];
    logic         t_clr [MAX_ROWS], t_auto [MAX_ROWS], t_bank [MAX_ROWS];
    ant_idx_t     t_req [MAX_ROWS];
    int           t_cyc [MAX_ROWS];
    int           n_rows = 0;
    int           total_cycles = 0;
    logic         tbl_ready = 1'b0;

    // reference model state
    int         boost_m [N];
    int         odp_cnt [N];                // consecutive over-limit samples
    dsa_atten_t exp_pl [N];
    dsa_atten_t last_loaded [N];            // what each DSA got on its last le
    tssi_t      cap_m [N];
    logic [N-1:0] flag_m, sleep_m, cap_vld, sw_m, en_m;
    logic       irq_m, le_prev;
    logic       model_ok = 1'b0;
    int         srx_st;                     // 0 on, 1 break, 2 make
    int         dwell_m;
    ant_idx_t   ant_m, auto_m;
    integer     seed = 32'h93e9;
    int         err_atten = 0, err_tssi = 0, err_ant = 0, err_bit = 0, err_other = 0;

    rf_control i_rf_control (.*);

    always #50 clk_3x = ~clk_3x;

    task automatic check_atten(input dsa_atten_t got, input dsa_atten_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_atten++;
        end
    endtask

    task automatic check_tssi(input tssi_t got, input tssi_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_tssi++;
        end
    endtask

    task automatic check_ant(input ant_idx_t got, input ant_idx_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_ant++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            err_bit++;
        end
    endtask

    task automatic add_row(input logic [N-1:0] orm, input logic [N-1:0] dis,
                           input logic [27:0] ps, input logic [N-1:0] hot,
                           input tssi_t tval, input tssi_t lim, input logic clr,
                           input logic aut, input ant_idx_t req, input logic bank, input int n);
        t_or[n_rows]   = orm;
        t_dis[n_rows]  = dis;
        t_ps[n_rows]   = ps;
        t_hot[n_rows]  = hot;
        t_tval[n_rows] = tval;
        t_lim[n_rows]  = lim;
        t_clr[n_rows]  = clr;
        t_auto[n_rows] = aut;
        t_req[n_rows]  = req;
        t_bank[n_rows] = bank;
        t_cyc[n_rows]  = n;
        total_cycles  += n;
        n_rows++;
    endtask

    task automatic apply_row(input int r);
        logic [31:0] rnd;
        adc_over_range = t_or[r];
        adcp_disable   = t_dis[r];
        for (int i = 0; i < N; i++) begin
            ps_rxdsa[i] = t_ps[r][7*i +: 7];
            tssi[i]     = t_hot[r][i] ? t_tval[r] : (t_lim[r] >> 1);   // cold ones sit at half
        end
        tssi_limit   = t_lim[r];
        odp_clear    = t_clr[r];
        srx_auto     = t_auto[r];
        srx_ant_req  = t_req[r];
        spi_bank_sel = t_bank[r];
        rnd = $random(seed);                    // fresh master pins every cycle
        {spi_ss_n, spi_sclk, spi_mosi, pa_spi1_miso} = rnd[9:0];
    endtask

    // radio bank lines in the upper half, PA lines in the lower
    task automatic check_spi();
        logic [23:0] got;
        logic [23:0] exp;
        got = {spi_miso, spi_tx_clk, spi_tx_d, spi_tx_le, spi_orx_clk, spi_orx_d, spi_orx_le,
               pa_spi1_sclk, pa_spi1_mosi, pa_spi1_cs, pa_spi2_sclk, pa_spi2_mosi, pa_spi2_le,
               pa_spi3_sclk, pa_spi3_mosi, pa_spi3_le};
        if (spi_bank_sel)
            exp = {1'b1, spi_sclk, spi_mosi, spi_ss_n[3:0], spi_sclk, spi_mosi,
                   spi_ss_n[5:4], 13'h1fff};
        else
            exp = {pa_spi1_miso, 10'h3ff, spi_sclk, spi_mosi, spi_ss_n[2:0], spi_sclk,
                   spi_mosi, spi_ss_n[4:3], spi_sclk, spi_mosi, spi_ss_n[6:5]};
        for (int b = 0; b < 24; b++)
            check_bit(got[b], exp[b], $sformatf("spi line bit %0d", b));
    endtask

    task automatic compare_outputs();
        for (int i = 0; i < N; i++) begin
            check_atten(pl_rxdsa[i], exp_pl[i], $sformatf("pl_rxdsa[%0d]", i));
            check_bit(odp_flag[i], flag_m[i], $sformatf("odp_flag[%0d]", i));
            check_bit(pa_ctrl_sleep[i], sleep_m[i], $sformatf("pa_ctrl_sleep[%0d]", i));
            check_bit(rf_switch_n[i], sw_m[i], $sformatf("rf_switch_n[%0d]", i));
            check_bit(rf_switch_en_n[i], en_m[i], $sformatf("rf_switch_en_n[%0d]", i));
            if (cap_vld[i])
                check_tssi(rf_overdrive_tssi[i], cap_m[i], $sformatf("overdrive tssi %0d", i));
        end
        check_bit(pa_irq, irq_m, "pa_irq");
        check_ant(srx_wrssi_ant, ant_m, "srx_wrssi_ant");
        if (rx_dsa_le != '0) begin
            if ((rx_dsa_le & (rx_dsa_le - 1'b1)) != '0 || le_prev) begin
                $display("DSA latch enables overlap or come in adjacent cycles at %0t", $time);
                err_other++;
            end
            for (int i = 0; i < N; i++) begin
                if (rx_dsa_le[i]) begin
                    check_atten(rx_dsa_d, exp_pl[i], $sformatf("rx_dsa_d for ch %0d", i));
                    last_loaded[i] = rx_dsa_d;
                end
            end
        end
        le_prev = |rx_dsa_le;
    endtask

    // next expected outputs from the inputs about to be clocked in
    task automatic update_model();
        ant_idx_t tgt;
        int sum;
        if (rst) begin
            for (int i = 0; i < N; i++) begin
                boost_m[i] = 0;
                odp_cnt[i] = 0;
                exp_pl[i] = '0;
                last_loaded[i] = '0;
            end
            {flag_m, cap_vld, irq_m, le_prev} = '0;
            sleep_m = host_sleep;
            {sw_m, en_m} = '1;
            srx_st = 1;                         // comes out of reset through break
            {ant_m, auto_m, dwell_m} = '0;
            model_ok = 1'b1;
        end else begin
            irq_m = 1'b0;
            for (int i = 0; i < N; i++) begin
                if (adcp_disable[i])
                    boost_m[i] = 0;
                else if (adc_over_range[i] && boost_m[i] < DSA_MAX)
                    boost_m[i]++;
                sum = ps_rxdsa[i] + boost_m[i];
                exp_pl[i] = (sum > DSA_MAX) ? DSA_MAX : dsa_atten_t'(sum);
                if (odp_clear) begin
                    odp_cnt[i] = 0;
                    flag_m[i] = 1'b0;
                end else if (tssi[i] > tssi_limit) begin
                    odp_cnt[i]++;
                    if (odp_cnt[i] == ODP_PERSIST && !flag_m[i]) begin   // trips only if not latched
                        flag_m[i]  = 1'b1;
                        cap_m[i]   = tssi[i];
                        cap_vld[i] = 1'b1;
                        irq_m      = 1'b1;
                    end
                end else begin
                    odp_cnt[i] = 0;
                end
            end
            sleep_m = host_sleep | flag_m;
            tgt = srx_auto ? auto_m : srx_ant_req;
            case (srx_st)
                0: if (tgt != ant_m) begin
                    srx_st = 1;
                    en_m = '1;
                end
                1: begin
                    srx_st = 2;
                    ant_m = tgt;
                    sw_m = ~(N'(1) << tgt);
                end
                default: begin
                    srx_st = 0;
                    en_m = ~(N'(1) << ant_m);
                end
            endcase
            if (!srx_auto) begin
                dwell_m = 0;
                auto_m = srx_ant_req;           // rotation starts from the manual pick
            end else begin
                dwell_m++;
                if (dwell_m == SRX_DWELL) begin
                    dwell_m = 0;
                    auto_m = ant_idx_t'((auto_m + 1) % N);
                end
            end
        end
    endtask

    // outputs settled half a cycle after the edge
    always @(negedge clk_3x) begin
        if (model_ok)
            compare_outputs();
        check_spi();
        update_model();
    end

    initial begin
        wait (tbl_ready);
        #((total_cycles + 200) * 100);
        $display("timeout: run did not finish within %0d cycles", total_cycles + 200);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int r;
        int c;
        {adc_over_range, adcp_disable, odp_clear, srx_auto, srx_ant_req} = '0;
        for (int i = 0; i < N; i++) begin
            ps_rxdsa[i] = '0;
            tssi[i] = '0;
        end
        tssi_limit = '0;
        host_sleep = 4'b0100;                   // PA 2 parked by the host
        {spi_bank_sel, spi_sclk, spi_mosi, spi_ss_n, pa_spi1_miso} = '1;
        //      or     dis    ps    hot    tval  limit clr aut req bank cyc
        add_row(4'h0, 4'h0, PS_A, 4'h0,    0, 1000, 0, 0, 0, 1, 12);  // initial loads
        add_row(4'h5, 4'h0, PS_A, 4'h0,    0, 1000, 0, 0, 2, 0, 6);   // boost ch0, ch2
        add_row(4'ha, 4'h1, PS_B, 4'h0,    0, 1000, 0, 0, 1, 1, 10);  // ch3 clips
        add_row(4'hf, 4'hf, PS_A, 4'h0,    0, 1000, 0, 0, 3, 0, 2);   // boosts dropped
        add_row(4'h0, 4'h0, PS_A, 4'h2, 2000, 2000, 0, 0, 3, 1, 5);   // at limit, not over
        add_row(4'h0, 4'h0, PS_A, 4'h2, 1200, 1000, 0, 0, 3, 0, 3);   // too short to trip
        add_row(4'h0, 4'h0, PS_A, 4'h0,    0, 1000, 0, 0, 3, 1, 2);
        add_row(4'h0, 4'h0, PS_A, 4'h2, 2200, 1000, 0, 0, 3, 0, 3);   // run builds up
        add_row(4'h0, 4'h0, PS_A, 4'h2, 2500, 1000, 0, 0, 3, 1, 1);   // trips PA 1 on this sample
        add_row(4'h0, 4'h0, PS_A, 4'h0,    0, 1000, 0, 0, 3, 0, 1);   // run broken
        add_row(4'h0, 4'h0, PS_A, 4'h2, 3000, 1000, 0, 0, 3, 1, 5);   // full new run while latched
        add_row(4'h0, 4'h0, PS_A, 4'h0,    0, 1000, 1, 0, 3, 0, 1);
        add_row(4'h0, 4'h0, PS_A, 4'h8, 1500, 1000, 0, 0, 3, 1, 6);   // trips PA 3
        add_row(4'h0, 4'h0, PS_A, 4'h0,    0, 1000, 1, 0, 0, 0, 4);
        add_row(4'h0, 4'h0, PS_A, 4'h0,    0, 1000, 0, 1, 0, 1, 70);  // auto rotation
        add_row(4'h0, 4'h0, PS_A, 4'h0,    0, 1000, 0, 0, 1, 0, 6);
        add_row(4'h0, 4'h0, PS_A, 4'h0,    0, 1000, 0, 0, 1, 1, 20);  // quiet tail
        tbl_ready = 1'b1;
        repeat (5) @(posedge clk_3x);
        #10;
        rst = 1'b0;
        for (r = 0; r < n_rows; r++) begin
            for (c = 0; c < t_cyc[r]; c++) begin
                apply_row(r);
                @(posedge clk_3x);
                #10;
            end
        end
        // every DSA should now hold its applied value
        for (int i = 0; i < N; i++)
            check_atten(last_loaded[i], exp_pl[i], $sformatf("last load of dsa %0d", i));
        $display("errors: atten %0d tssi %0d ant %0d bit %0d other %0d",
                 err_atten, err_tssi, err_ant, err_bit, err_other);
        if (err_atten + err_tssi + err_ant + err_bit + err_other == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* logic/rf_control.sv */
`timescale 1ns/100ps

module rf_control import rf_ctrl_pkg::*; #(
    parameter int N_ANTENNAS  = 4,
    parameter int ODP_PERSIST = 4,
    parameter int SRX_DWELL   = 16
) (
    input  logic                  clk_3x,
    input  logic                  rst,
    // receive gain
    input  logic [N_ANTENNAS-1:0] adc_over_range,
    input  logic [N_ANTENNAS-1:0] adcp_disable,
    input  dsa_atten_t            ps_rxdsa [N_ANTENNAS],
    output dsa_atten_t            pl_rxdsa [N_ANTENNAS],
    output dsa_atten_t            rx_dsa_d,
    output logic [N_ANTENNAS-1:0] rx_dsa_le,
    // PA protection
    input  tssi_t                 tssi [N_ANTENNAS],
    input  tssi_t                 tssi_limit,
    input  logic                  odp_clear,
    input  logic [N_ANTENNAS-1:0] host_sleep,
    output tssi_t                 rf_overdrive_tssi [N_ANTENNAS],
    output logic [N_ANTENNAS-1:0] odp_flag,
    output logic                  pa_irq,
    output logic [N_ANTENNAS-1:0] pa_ctrl_sleep,
    // observation rx
    input  logic                  srx_auto,
    input  ant_idx_t              srx_ant_req,
    output ant_idx_t              srx_wrssi_ant,
    output logic [N_ANTENNAS-1:0] rf_switch_n,
    output logic [N_ANTENNAS-1:0] rf_switch_en_n,
    // processor SPI master and board banks
    input  logic                  spi_bank_sel,
    input  logic                  spi_sclk,
    input  logic                  spi_mosi,
    input  logic [6:0]            spi_ss_n,
    input  logic                  pa_spi1_miso,
    output logic                  spi_miso,
    output logic                  spi_tx_clk,
    output logic                  spi_tx_d,
    output logic [3:0]            spi_tx_le,
    output logic                  spi_orx_clk,
    output logic                  spi_orx_d,
    output logic [1:0]            spi_orx_le,
    output logic                  pa_spi1_sclk,
    output logic                  pa_spi1_mosi,
    output logic [2:0]            pa_spi1_cs,
    output logic                  pa_spi2_sclk,
    output logic                  pa_spi2_mosi,
    output logic [1:0]            pa_spi2_le,
    output logic                  pa_spi3_sclk,
    output logic                  pa_spi3_mosi,
    output logic [1:0]            pa_spi3_le
);

    // port names line up with the blocks below
    agc_dsa_ctrl #(.N_ANTENNAS(N_ANTENNAS)) i_agc_dsa_ctrl (.*);

    pa_overdrive_guard #(
        .N_ANTENNAS  (N_ANTENNAS),
        .ODP_PERSIST (ODP_PERSIST)
    ) i_pa_overdrive_guard (.*);

    srx_ant_select #(
        .N_ANTENNAS (N_ANTENNAS),
        .SRX_DWELL  (SRX_DWELL)
    ) i_srx_ant_select (.*);

    spi_bank_mux i_spi_bank_mux (.*);   // combinational, no clock

endmodule

/* logic/spi_bank_mux.sv */
`timescale 1ns/100ps

module spi_bank_mux (
    input  logic       spi_bank_sel,    // 1 radio board, 0 PA board
    input  logic       spi_sclk,
    input  logic       spi_mosi,
    input  logic [6:0] spi_ss_n,
    input  logic       pa_spi1_miso,
    output logic       spi_miso,
    output logic       spi_tx_clk,
    output logic       spi_tx_d,
    output logic [3:0] spi_tx_le,       // tx DSAs
    output logic       spi_orx_clk,
    output logic       spi_orx_d,
    output logic [1:0] spi_orx_le,      // orx DSAs
    output logic       pa_spi1_sclk,
    output logic       pa_spi1_mosi,
    output logic [2:0] pa_spi1_cs,      // eeprom and PA controllers
    output logic       pa_spi2_sclk,
    output logic       pa_spi2_mosi,
    output logic [1:0] pa_spi2_le,      // doherty align
    output logic       pa_spi3_sclk,
    output logic       pa_spi3_mosi,
    output logic [1:0] pa_spi3_le
);

    // radio board bank
    assign spi_tx_clk   = spi_bank_sel ? spi_sclk       : 1'b1;
    assign spi_tx_d     = spi_bank_sel ? spi_mosi       : 1'b1;
    assign spi_tx_le    = spi_bank_sel ? spi_ss_n[3:0]  : 4'hf;
    assign spi_orx_clk  = spi_bank_sel ? spi_sclk       : 1'b1;
    assign spi_orx_d    = spi_bank_sel ? spi_mosi       : 1'b1;
    assign spi_orx_le   = spi_bank_sel ? spi_ss_n[5:4]  : 2'b11;

    // PA board bank, idles high when radio bank owns the master
    assign pa_spi1_sclk = spi_bank_sel ? 1'b1  : spi_sclk;
    assign pa_spi1_mosi = spi_bank_sel ? 1'b1  : spi_mosi;
    assign pa_spi1_cs   = spi_bank_sel ? 3'h7  : spi_ss_n[2:0];
    assign pa_spi2_sclk = spi_bank_sel ? 1'b1  : spi_sclk;
    assign pa_spi2_mosi = spi_bank_sel ? 1'b1  : spi_mosi;
    assign pa_spi2_le   = spi_bank_sel ? 2'b11 : spi_ss_n[4:3];
    assign pa_spi3_sclk = spi_bank_sel ? 1'b1  : spi_sclk;
    assign pa_spi3_mosi = spi_bank_sel ? 1'b1  : spi_mosi;
    assign pa_spi3_le   = spi_bank_sel ? 2'b11 : spi_ss_n[6:5];

    // radio bank parts are write only
    assign spi_miso     = spi_bank_sel ? 1'b1  : pa_spi1_miso;

endmodule

/* logic/srx_ant_select.sv */
`timescale 1ns/100ps

module srx_ant_select import rf_ctrl_pkg::*; #(
    parameter int N_ANTENNAS = 4,
    parameter int SRX_DWELL  = 16
) (
    input  logic                  clk_3x,
    input  logic                  rst,
    input  logic                  srx_auto,         // rotate through antennas
    input  ant_idx_t              srx_ant_req,      // manual choice
    output ant_idx_t              srx_wrssi_ant,    // antenna now switched in
    output logic [N_ANTENNAS-1:0] rf_switch_n,      // one-hot, active low
    output logic [N_ANTENNAS-1:0] rf_switch_en_n
);

    localparam int       DW       = (SRX_DWELL > 1) ? $clog2(SRX_DWELL) : 1;
    localparam ant_idx_t LAST_ANT = ant_idx_t'(N_ANTENNAS - 1);

    srx_state_e    state;
    logic [DW-1:0] dwell_cnt;
    ant_idx_t      auto_ant;                        // rotation position
    ant_idx_t      target;

    assign target = srx_auto ? auto_ant : srx_ant_req;

    // dwell timer for auto mode
    always_ff @(posedge clk_3x) begin
        if (rst) begin
            dwell_cnt <= '0;
            auto_ant  <= '0;
        end else if (!srx_auto) begin
            dwell_cnt <= '0;
            auto_ant  <= srx_ant_req;               // rotation resumes from manual pick
        end else if (dwell_cnt == DW'(SRX_DWELL - 1)) begin
            dwell_cnt <= '0;
            auto_ant  <= (auto_ant == LAST_ANT) ? '0 : auto_ant + 1'b1;
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // break-before-make sequencer
    always_ff @(posedge clk_3x) begin
        if (rst) begin
            state          <= SRX_BREAK;            // comes up through a clean make
            srx_wrssi_ant  <= '0;
            rf_switch_n    <= '1;
            rf_switch_en_n <= '1;
        end else begin
            case (state)
                SRX_ON: begin
                    if (target != srx_wrssi_ant) begin
                        state          <= SRX_BREAK;
                        rf_switch_en_n <= '1;       // all paths off first
                    end
                end
                SRX_BREAK: begin
                    state         <= SRX_MAKE;
                    srx_wrssi_ant <= target;
                    rf_switch_n   <= ~(N_ANTENNAS'(1) << target);
                end
                SRX_MAKE: begin
                    state          <= SRX_ON;
                    rf_switch_en_n <= ~(N_ANTENNAS'(1) << srx_wrssi_ant);
                end
                default: state <= SRX_BREAK;
            endcase
        end
    end

    // switch moves only with enables off now and a cycle before
    a_bbm: assert property (@(posedge clk_3x) disable iff (rst)
        !$stable(rf_switch_n) |-> (&rf_switch_en_n && &$past(rf_switch_en_n)));

    a_one_en: assert property (@(posedge clk_3x) disable iff (rst)
        $onehot0(~rf_switch_en_n));

endmodule

/* logic/pa_overdrive_guard.sv */
`timescale 1ns/100ps

module pa_overdrive_guard import rf_ctrl_pkg::*; #(
    parameter int N_ANTENNAS  = 4,
    parameter int ODP_PERSIST = 4
) (
    input  logic                  clk_3x,
    input  logic                  rst,
    input  tssi_t                 tssi [N_ANTENNAS],   // detector per antenna
    input  tssi_t                 tssi_limit,          // host threshold
    input  logic                  odp_clear,           // drops every latched trip
    input  logic [N_ANTENNAS-1:0] host_sleep,
    output tssi_t                 rf_overdrive_tssi [N_ANTENNAS],
    output logic [N_ANTENNAS-1:0] odp_flag,
    output logic                  pa_irq,
    output logic [N_ANTENNAS-1:0] pa_ctrl_sleep
);

    localparam int CW = $clog2(ODP_PERSIST + 1);

    logic [CW-1:0]         over_cnt [N_ANTENNAS];   // consecutive samples above limit
    logic [N_ANTENNAS-1:0] over;
    logic [N_ANTENNAS-1:0] trip;                    // new trip on this edge
    logic [N_ANTENNAS-1:0] flag_nxt;

    always_comb begin
        for (int i = 0; i < N_ANTENNAS; i++) begin
            over[i] = (tssi[i] > tssi_limit);
            // latched antennas stay quiet until cleared
            trip[i] = over[i] && !odp_flag[i] && !odp_clear &&
                      (over_cnt[i] == CW'(ODP_PERSIST - 1));
        end
    end

    assign flag_nxt = odp_clear ? '0 : (odp_flag | trip);

    always_ff @(posedge clk_3x) begin
        if (rst) begin
            for (int i = 0; i < N_ANTENNAS; i++)
                over_cnt[i] <= '0;
            odp_flag      <= '0;
            pa_irq        <= 1'b0;
            pa_ctrl_sleep <= host_sleep;            // host bits pass through in reset
        end else begin
            for (int i = 0; i < N_ANTENNAS; i++) begin
                if (odp_clear || !over[i])
                    over_cnt[i] <= '0;              // run broken
                else if (over_cnt[i] != CW'(ODP_PERSIST))
                    over_cnt[i] <= over_cnt[i] + 1'b1;
            end
            odp_flag      <= flag_nxt;
            pa_ctrl_sleep <= host_sleep | flag_nxt; // tripped PA forced asleep
            pa_irq        <= |trip;                 // registered OR of new trips
        end
    end

    // sample that caused the trip
    always_ff @(posedge clk_3x) begin
        for (int i = 0; i < N_ANTENNAS; i++) begin
            if (trip[i])
                rf_overdrive_tssi[i] <= tssi[i];
        end
    end

    a_irq_pulse: assert property (@(posedge clk_3x) disable iff (rst)
        pa_irq |=> !pa_irq);

    // overdrive flag always backed by a sleeping PA
    a_flag_sleep: assert property (@(posedge clk_3x) disable iff (rst)
        (odp_flag & ~pa_ctrl_sleep) == '0);

endmodule

/* logic/agc_dsa_ctrl.sv */
`timescale 1ns/100ps

module agc_dsa_ctrl import rf_ctrl_pkg::*; #(
    parameter int N_ANTENNAS = 4
) (
    input  logic                  clk_3x,
    input  logic                  rst,
    input  logic [N_ANTENNAS-1:0] adc_over_range,   // per rx channel
    input  logic [N_ANTENNAS-1:0] adcp_disable,     // high drops the boost
    input  dsa_atten_t            ps_rxdsa [N_ANTENNAS],   // host request
    output dsa_atten_t            pl_rxdsa [N_ANTENNAS],   // applied value
    output dsa_atten_t            rx_dsa_d,                 // shared DSA data bus
    output logic [N_ANTENNAS-1:0] rx_dsa_le                 // latch enable per channel
);

    localparam int PW = (N_ANTENNAS > 1) ? $clog2(N_ANTENNAS) : 1;

    dsa_atten_t            boost     [N_ANTENNAS];  // over-range attenuation added
    dsa_atten_t            boost_nxt [N_ANTENNAS];
    dsa_atten_t            pl_nxt    [N_ANTENNAS];  // applied value, ready for next edge
    dsa_atten_t            loaded    [N_ANTENNAS];  // what each DSA holds now
    logic [7:0]            sum       [N_ANTENNAS];  // one extra bit for the clip
    logic [N_ANTENNAS-1:0] dirty;
    logic [PW-1:0]         rr_ptr;                  // first channel to look at
    logic [PW-1:0]         pick;
    logic                  pick_vld;

    // boost and clipped applied value per channel
    always_comb begin
        for (int i = 0; i < N_ANTENNAS; i++) begin
            if (adcp_disable[i]) begin
                boost_nxt[i] = '0;
            end else if (adc_over_range[i] && boost[i] != DSA_MAX) begin
                boost_nxt[i] = boost[i] + 1'b1;     // saturates at DSA_MAX
            end else begin
                boost_nxt[i] = boost[i];
            end
            sum[i]    = {1'b0, ps_rxdsa[i]} + {1'b0, boost_nxt[i]};
            pl_nxt[i] = (sum[i] > {1'b0, DSA_MAX}) ? DSA_MAX : sum[i][6:0];
            dirty[i]  = (pl_nxt[i] != loaded[i]);  // DSA out of date
        end
    end

    // round-robin search from rr_ptr
    always_comb begin
        int idx;
        pick     = rr_ptr;
        pick_vld = 1'b0;
        // walk backwards so the nearest dirty channel is the one left standing
        for (int k = N_ANTENNAS - 1; k >= 0; k--) begin
            idx = int'(rr_ptr) + k;
            if (idx >= N_ANTENNAS)
                idx = idx - N_ANTENNAS;             // wrap around
            if (dirty[idx]) begin
                pick     = PW'(idx);
                pick_vld = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_3x) begin
        if (rst) begin
            for (int i = 0; i < N_ANTENNAS; i++) begin
                boost[i]    <= '0;
                pl_rxdsa[i] <= '0;
                loaded[i]   <= '0;
            end
            rx_dsa_d  <= '0;
            rx_dsa_le <= '0;
            rr_ptr    <= '0;
        end else begin
            boost     <= boost_nxt;
            pl_rxdsa  <= pl_nxt;
            rx_dsa_le <= '0;                        // le is a single-cycle strobe
            // idle cycle after every load keeps loads two apart
            if (pick_vld && rx_dsa_le == '0) begin
                rx_dsa_d        <= pl_nxt[pick];    // data valid with its le
                rx_dsa_le[pick] <= 1'b1;
                loaded[pick]    <= pl_nxt[pick];
                rr_ptr          <= (pick == PW'(N_ANTENNAS - 1)) ? '0 : pick + 1'b1;
            end
        end
    end

    // one channel latched per strobe
    a_le_onehot: assert property (@(posedge clk_3x) disable iff (rst)
        $onehot0(rx_dsa_le));

    // latch strobes never back to back
    a_le_gap: assert property (@(posedge clk_3x) disable iff (rst)
        |rx_dsa_le |=> rx_dsa_le == '0);

endmodule

/* logic/rf_ctrl_pkg.sv */
package rf_ctrl_pkg;

    // receive DSA code, one attenuation step per lsb
    typedef logic [6:0] dsa_atten_t;

    localparam dsa_atten_t DSA_MAX = 7'd127;    // full attenuation

    // PA detector reading
    // larger value means more output power
    typedef logic [31:0] tssi_t;

    typedef logic [1:0] ant_idx_t;              // antenna number, up to four

    // observation RF switch sequencer
    typedef enum logic [1:0] {
        SRX_ON,         // selected path enabled
        SRX_BREAK,      // every path disabled
        SRX_MAKE        // switch moved, paths still disabled
    } srx_state_e;

endpackage
